/* project.f */
+incdir+tb
source/arm_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/forward_unit.sv
source/barrel_shifter.sv
source/alu.sv
source/execute_unit.sv
source/arm_core.sv
tb/tb_arm_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_arm_core
RTL_TOP    ?= arm_core
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
BUILD_OPTS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_OPTS  ?= --lint-only --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard source/*.sv tb/*.sv tb/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_OPTS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/arm_model.svh */
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

// Expected results, built before reset is released
logic [31:0] fetch_q [$]; // Every pc the core presents, wrong-path fetches too
logic [39:0] write_q [$]; // {flags, rd, data}
logic [31:0] model_regs [16];
logic [3:0]  model_flags;

function automatic bit cond_holds(input logic [3:0] cond);
    logic n, z, c, v;
    bit   base;
    {n, z, c, v} = model_flags;
    case (cond[3:1])
        3'd0:    base = z;
        3'd1:    base = c;
        3'd2:    base = n;
        3'd3:    base = v;
        3'd4:    base = c && !z;
        3'd5:    base = (n == v);
        3'd6:    base = !z && (n == v);
        default: base = 1'b1;
    endcase
    return base ^ cond[0]; // Odd codes are the inverse
endfunction

function automatic bit writes_reg(input logic [31:0] w);
    if (w == '0 || w[24:23] == 2'b10)
        return 1'b0;
    return (w[27:25] == 3'b001) || (w[27:25] == 3'b000 && !w[4]);
endfunction

function automatic logic [31:0] operand2(input logic [31:0] w);
    logic [31:0] val;
    logic [4:0]  amt;
    if (w[25]) begin
        val = {24'd0, w[7:0]};
        amt = {w[11:8], 1'b0};
    end else begin
        val = model_regs[w[3:0]];
        amt = w[11:7];
    end
    if (w[25] || w[6:5] == 2'b11) begin
        repeat (amt) val = {val[0], val[31:1]}; // One place at a time
    end else if (w[6:5] == 2'b10) begin
        repeat (amt) val = {val[31], val[31:1]};
    end else if (w[6:5] == 2'b01) begin
        val = val >> amt;
    end else begin
        val = val << amt;
    end
    return val;
endfunction

task automatic exec_dp(input logic [31:0] w);
    logic [3:0]  op;
    logic [31:0] a, b, x, y, res;
    logic        cin, c, v;
    longint      wide, sw;
    op  = w[24:21];
    a   = model_regs[w[19:16]];
    b   = operand2(w);
    cin = (op == op_adc || op == op_sbc || op == op_rsc) ? model_flags[1] : 1'b0;
    x   = (op == op_rsb || op == op_rsc) ? b : a;
    y   = (op == op_rsb || op == op_rsc) ? a : b;
    c   = 1'b0;
    v   = 1'b0;
    case (op)
        op_and: res = a & b;
        op_eor: res = a ^ b;
        op_orr: res = a | b;
        op_mov: res = b;
        op_bic: res = a & ~b;
        op_mvn: res = ~b;
        op_add, op_adc: begin
            wide = longint'(a) + longint'(b) + longint'(cin);
            sw   = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
            res  = wide[31:0];
            c    = wide[32];
            v    = (sw != longint'($signed(res)));
        end
        default: begin
            wide = longint'(x) - longint'(y) - longint'(cin);
            sw   = longint'($signed(x)) - longint'($signed(y)) - longint'(cin);
            res  = wide[31:0];
            c    = (wide < 0); // Borrow
            v    = (sw != longint'($signed(res)));
        end
    endcase
    if (w[20])
        model_flags = {res[31], res == '0, c, v};
    model_regs[w[15:12]] = res;
    write_q.push_back({model_flags, w[15:12], res});
endtask

task automatic run_model();
    logic [31:0] mpc;
    logic [31:0] w;
    logic [31:0] target;
    int          loops;
    mpc         = '0;
    loops       = 0;
    model_flags = '0;
    foreach (model_regs[i])
        model_regs[i] = '0;
    while (loops < 4 && fetch_q.size() < max_cycles) begin
        w = rom[mpc[9:2]];
        fetch_q.push_back(mpc);
        if (w[27:25] == class_branch && !w[24] && cond_holds(w[31:28])) begin
            target = mpc + 32'd4 + {{6{w[23]}}, w[23:0], 2'b00};
            fetch_q.push_back(mpc + 32'd4); // Squashed in the core
            if (target == mpc)
                loops++;
            mpc = target;
        end else begin
            if (writes_reg(w))
                exec_dp(w);
            mpc = mpc + 32'd4;
        end
    end
endtask

`endif

/* tb/tb_arm_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_arm_core;
    import arm_pkg::*;

    localparam int rom_words  = 256;
    localparam int last_idx   = 239; // Final self-branch
    localparam int max_cycles = 2000;

    localparam logic [3:0] kept_ops [12] = '{op_and, op_eor, op_sub, op_rsb, op_add, op_adc,
                                              op_sbc, op_rsc, op_orr, op_mov, op_bic, op_mvn};

    logic                  clk;
    logic                  rst_n;
    logic [word_w-1:0]     instr;
    logic [word_w-1:0]     pc;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_rd;
    logic [word_w-1:0]     wb_data;
    logic [3:0]            flags;

    logic [word_w-1:0] rom [rom_words];
    logic [3:0]        last_flags;
    logic              seen_write;

    `include "arm_model.svh"

    arm_core DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .flags   (flags)
    );

    assign instr = rom[pc[9:2]]; // ROM answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [3:0] any_op();
        return kept_ops[$urandom_range(11, 0)];
    endfunction

    function automatic logic [4:0] pick_amount();
        case ($urandom_range(3, 0))
            0:       return 5'd0;
            1:       return 5'd31;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic logic [11:0] shift_operand(input logic [1:0] kind, input logic [4:0] amount);
        return {amount, kind, 1'b0, 4'($urandom_range(7, 0))};
    endfunction

    // Few registers, so most operands depend on recent results
    function automatic logic [31:0] dp_word(input logic [3:0] op, input logic imm, input logic s,
                                            input logic [11:0] operand);
        instr_t w;
        w.dp.cond    = 4'($urandom_range(14, 0));
        w.dp.cls     = imm ? class_dp_imm : class_dp_reg;
        w.dp.opcode  = op;
        w.dp.s       = s;
        w.dp.rn      = 4'($urandom_range(7, 0));
        w.dp.rd      = 4'($urandom_range(7, 0));
        w.dp.operand = operand;
        return w;
    endfunction

    function automatic logic [31:0] branch_word(input logic [3:0] cond, input logic [23:0] offset);
        instr_t w;
        w.br.cond   = cond;
        w.br.cls    = class_branch;
        w.br.link   = 1'b0;
        w.br.offset = offset;
        return w;
    endfunction

    function automatic logic [31:0] random_word(input int idx);
        int span;
        int pick;
        span = last_idx - idx - 1; // Forward targets stay inside the program
        pick = int'($urandom_range(99, 0));
        if (pick < 12)
            return branch_word(4'($urandom_range(14, 0)),
                               24'($urandom_range((span < 3) ? span : 3, 0)));
        if (pick < 14)
            return '0;
        if (pick < 18)
            return dp_word({2'b10, 2'($urandom)}, 1'b1, 1'b1, 12'($urandom)); // Compare group
        if (pick < 56)
            return dp_word(any_op(), 1'b1, 1'($urandom), 12'($urandom));
        return dp_word(any_op(), 1'b0, 1'($urandom), shift_operand(2'($urandom), pick_amount()));
    endfunction

    task automatic fill_rom();
        for (int i = 0; i < rom_words; i++) begin
            if (i < 12)
                rom[i] = dp_word(kept_ops[i], 1'b1, 1'b1, 12'($urandom));
            else if (i < 20)
                rom[i] = dp_word(any_op(), 1'b0, 1'b1,
                                 shift_operand(2'((i - 12) / 2), (i % 2 == 1) ? 5'd31 : 5'd0));
            else if (i < last_idx)
                rom[i] = random_word(i);
            else if (i == last_idx)
                rom[i] = branch_word(cond_al, 24'hff_ffff);
            else
                rom[i] = dp_word(any_op(), 1'b1, 1'b1, 12'($urandom)); // Wrong path only
        end
    endtask

    task automatic check_outputs(input int cycle);
        logic [word_w-1:0] exp_pc;
        logic [39:0]       exp;
        exp_pc = fetch_q.pop_front();
        pc_seq: assert (pc == exp_pc) else show_mismatch("pc", pc, exp_pc);
        if (!wb_en) begin
            flags_hold: assert (flags == last_flags)
                else show_mismatch("flags", 32'(flags), 32'(last_flags));
        end else if (write_q.size() == 0) begin
            abort_run("register write-back with no instruction left to retire");
        end else begin
            exp = write_q.pop_front();
            first_wb: assert (seen_write || cycle == 3)
                else abort_run("first write-back did not come 3 cycles after the first fetch");
            rd_ok: assert (wb_rd == exp[35:32])
                else show_mismatch("wb_rd", 32'(wb_rd), 32'(exp[35:32]));
            data_ok: assert (wb_data == exp[31:0])
                else show_mismatch("wb_data", wb_data, exp[31:0]);
            flags_ok: assert (flags == exp[39:36])
                else show_mismatch("flags", 32'(flags), 32'(exp[39:36]));
            seen_write = 1'b1;
            last_flags = exp[39:36];
        end
    endtask

    initial begin
        int cycle;
        rst_n      = 1'b0;
        last_flags = '0;
        seen_write = 1'b0;
        void'($urandom(32'h405a));
        fill_rom();
        run_model();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        cycle = 0;
        while (fetch_q.size() > 0) begin
            @(negedge clk);
            check_outputs(cycle);
            cycle++;
            if (cycle > max_cycles)
                abort_run("timed out before the program reached its final loop");
        end
        if (write_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("register writes of the program never retired");
        end
    end

endmodule

`default_nettype wire

/* source/arm_core.sv */
`timescale 1ns/100ps
`default_nettype none

module arm_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [arm_pkg::word_w-1:0]     instr,
    output logic [arm_pkg::word_w-1:0]     pc,
    output logic                            wb_en,
    output logic [arm_pkg::reg_addr_w-1:0] wb_rd,
    output logic [arm_pkg::word_w-1:0]     wb_data,
    output logic [3:0]                      flags
);
    import arm_pkg::*;

    instr_t                id_instr;
    logic [word_w-1:0]     id_next_pc;
    logic                  branch_taken;
    logic [word_w-1:0]     branch_target;
    logic [reg_addr_w-1:0] rn_idx;
    logic [reg_addr_w-1:0] rm_idx;
    logic [reg_addr_w-1:0] rd;
    logic [3:0]            alu_op;
    logic                  imm_mode;
    logic                  s_en;
    logic                  wr_en;
    logic [11:0]           operand_field;
    logic [word_w-1:0]     rn_file;
    logic [word_w-1:0]     rm_file;
    logic [word_w-1:0]     rn_value;
    logic [word_w-1:0]     rm_value;
    logic                  ex_wr_en;
    logic [reg_addr_w-1:0] ex_rd;
    logic [word_w-1:0]     ex_result;
    logic [3:0]            cond_flags;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .instr         (instr),
        .pc            (pc),
        .id_instr      (id_instr),
        .id_next_pc    (id_next_pc)
    );

    decode_unit u_decode (
        .id_instr      (id_instr),
        .id_next_pc    (id_next_pc),
        .flags         (cond_flags),
        .rn_idx        (rn_idx),
        .rm_idx        (rm_idx),
        .rd            (rd),
        .alu_op        (alu_op),
        .imm_mode      (imm_mode),
        .s_en          (s_en),
        .wr_en         (wr_en),
        .operand_field (operand_field),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wb_en),
        .wr_idx  (wb_rd),
        .wr_data (wb_data),
        .rn_idx  (rn_idx),
        .rm_idx  (rm_idx),
        .rn_data (rn_file),
        .rm_data (rm_file)
    );

    forward_unit u_forward (
        .rn_idx    (rn_idx),
        .rm_idx    (rm_idx),
        .rn_file   (rn_file),
        .rm_file   (rm_file),
        .ex_wr_en  (ex_wr_en),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .rn_value  (rn_value),
        .rm_value  (rm_value)
    );

    execute_unit u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd            (rd),
        .alu_op        (alu_op),
        .imm_mode      (imm_mode),
        .s_en          (s_en),
        .wr_en         (wr_en),
        .operand_field (operand_field),
        .rn_value      (rn_value),
        .rm_value      (rm_value),
        .ex_wr_en      (ex_wr_en),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .cond_flags    (cond_flags),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .flags         (flags)
    );

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [arm_pkg::reg_addr_w-1:0] rd,
    input  logic [3:0]                      alu_op,
    input  logic                            imm_mode,
    input  logic                            s_en,
    input  logic                            wr_en,
    input  logic [11:0]                     operand_field,
    input  logic [arm_pkg::word_w-1:0]     rn_value,
    input  logic [arm_pkg::word_w-1:0]     rm_value,
    output logic                            ex_wr_en,
    output logic [arm_pkg::reg_addr_w-1:0] ex_rd,
    output logic [arm_pkg::word_w-1:0]     ex_result,
    output logic [3:0]                      cond_flags,
    output logic                            wb_en,
    output logic [arm_pkg::reg_addr_w-1:0] wb_rd,
    output logic [arm_pkg::word_w-1:0]     wb_data,
    output logic [3:0]                      flags
);
    import arm_pkg::*;

    logic              ex_s_en;
    logic [3:0]        ex_alu_op;
    logic              ex_imm_mode;
    logic [11:0]       ex_operand;
    logic [word_w-1:0] ex_rn;
    logic [word_w-1:0] ex_rm;
    logic [word_w-1:0] operand_b;
    logic [3:0]        alu_flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wr_en <= 1'b0;
            ex_s_en  <= 1'b0;
        end else begin
            ex_wr_en <= wr_en;
            ex_s_en  <= s_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd       <= rd;
        ex_alu_op   <= alu_op;
        ex_imm_mode <= imm_mode;
        ex_operand  <= operand_field;
        ex_rn       <= rn_value;
        ex_rm       <= rm_value;
    end

    barrel_shifter u_shifter (
        .rm_value      (ex_rm),
        .operand_field (ex_operand),
        .imm_mode      (ex_imm_mode),
        .operand_b     (operand_b)
    );

    alu u_alu (
        .alu_op    (ex_alu_op),
        .operand_a (ex_rn),
        .operand_b (operand_b),
        .carry_in  (flags[1]),
        .result    (ex_result),
        .flags_out (alu_flags)
    );

    // Branch in decode sees the flags of the instruction now in EX
    assign cond_flags = ex_s_en ? alu_flags : flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
            flags <= '0;
        end else begin
            wb_en <= ex_wr_en;
            if (ex_s_en) begin
                flags <= alu_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [3:0]                  alu_op,
    input  logic [arm_pkg::word_w-1:0] operand_a,
    input  logic [arm_pkg::word_w-1:0] operand_b,
    input  logic                        carry_in,
    output logic [arm_pkg::word_w-1:0] result,
    output logic [3:0]                  flags_out
);
    import arm_pkg::*;

    localparam int msb = word_w - 1;

    logic              use_carry;
    logic              reverse;
    logic [word_w:0]   carry_ext;
    logic [word_w:0]   sum;
    logic [word_w:0]   diff;
    logic [word_w-1:0] sub_x;
    logic [word_w-1:0] sub_y;
    logic              c_out;
    logic              v_out;

    assign use_carry = (alu_op == op_adc) || (alu_op == op_sbc) || (alu_op == op_rsc);
    assign reverse   = (alu_op == op_rsb) || (alu_op == op_rsc);
    assign carry_ext = {{word_w{1'b0}}, use_carry & carry_in};

    assign sub_x = reverse ? operand_b : operand_a;
    assign sub_y = reverse ? operand_a : operand_b;
    assign sum   = {1'b0, operand_a} + {1'b0, operand_b} + carry_ext;
    assign diff  = {1'b0, sub_x} - {1'b0, sub_y} - carry_ext; // Top bit is the borrow

    always_comb begin
        c_out = 1'b0;
        v_out = 1'b0;
        case (alu_op)
            op_and: result = operand_a & operand_b;
            op_eor: result = operand_a ^ operand_b;
            op_orr: result = operand_a | operand_b;
            op_mov: result = operand_b;
            op_bic: result = operand_a & ~operand_b;
            op_mvn: result = ~operand_b;
            op_add, op_adc: begin
                result = sum[msb:0];
                c_out  = sum[word_w];
                v_out  = (operand_a[msb] ~^ operand_b[msb]) & (operand_a[msb] ^ result[msb]);
            end
            op_sub, op_rsb, op_sbc, op_rsc: begin
                result = diff[msb:0];
                c_out  = diff[word_w];
                v_out  = (sub_x[msb] ^ sub_y[msb]) & (sub_x[msb] ^ result[msb]);
            end
            default: result = '0;
        endcase
    end

    // N Z C V
    assign flags_out = {result[msb], result == '0, c_out, v_out};

endmodule

`default_nettype wire

/* source/barrel_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module barrel_shifter (
    input  logic [arm_pkg::word_w-1:0] rm_value,
    input  logic [11:0]                 operand_field,
    input  logic                        imm_mode,
    output logic [arm_pkg::word_w-1:0] operand_b
);
    import arm_pkg::*;

    logic [4:0]          amount;
    logic [1:0]          kind;
    logic [word_w-1:0]   rot_src;
    logic [2*word_w-1:0] rotated;

    assign kind = operand_field[6:5];

    // Immediate rotates by twice the 4-bit field
    assign amount  = imm_mode ? {operand_field[11:8], 1'b0} : operand_field[11:7];
    assign rot_src = imm_mode ? {{(word_w-8){1'b0}}, operand_field[7:0]} : rm_value;
    assign rotated = {rot_src, rot_src} >> amount;

    // Amount 0 passes rm through for every type
    always_comb begin
        operand_b = rotated[word_w-1:0];
        if (!imm_mode) begin
            case (kind)
                shift_lsl: operand_b = rm_value << amount;
                shift_lsr: operand_b = rm_value >> amount;
                shift_asr: operand_b = word_w'($signed(rm_value) >>> amount);
                shift_ror: operand_b = rotated[word_w-1:0];
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/forward_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    input  logic [arm_pkg::reg_addr_w-1:0] rn_idx,
    input  logic [arm_pkg::reg_addr_w-1:0] rm_idx,
    input  logic [arm_pkg::word_w-1:0]     rn_file,
    input  logic [arm_pkg::word_w-1:0]     rm_file,
    input  logic                            ex_wr_en,
    input  logic [arm_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [arm_pkg::word_w-1:0]     ex_result,
    input  logic                            wb_en,
    input  logic [arm_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [arm_pkg::word_w-1:0]     wb_data,
    output logic [arm_pkg::word_w-1:0]     rn_value,
    output logic [arm_pkg::word_w-1:0]     rm_value
);
    import arm_pkg::*;

    logic [1:0] rn_sel;
    logic [1:0] rm_sel;
    logic       both_match;

    function automatic logic [1:0] pick(input logic [reg_addr_w-1:0] idx);
        if (ex_wr_en && ex_rd == idx)
            return fwd_ex; // Youngest producer wins
        if (wb_en && wb_rd == idx)
            return fwd_wb;
        return fwd_file;
    endfunction

    function automatic logic [word_w-1:0] route(input logic [1:0] sel,
                                                input logic [word_w-1:0] file_value);
        case (sel)
            fwd_ex:  return ex_result;
            fwd_wb:  return wb_data;
            default: return file_value;
        endcase
    endfunction

    always_comb begin
        rn_sel   = pick(rn_idx);
        rm_sel   = pick(rm_idx);
        rn_value = route(rn_sel, rn_file);
        rm_value = route(rm_sel, rm_file);
    end

    assign both_match = ex_wr_en && wb_en && (ex_rd == wb_rd);

    always_comb begin
        assert final (!(both_match && rn_idx == ex_rd) || rn_value == ex_result)
            else $error("rn took the older write-back value");
        assert final (!(both_match && rm_idx == ex_rd) || rm_value == ex_result)
            else $error("rm took the older write-back value");
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [arm_pkg::reg_addr_w-1:0] wr_idx,
    input  logic [arm_pkg::word_w-1:0]     wr_data,
    input  logic [arm_pkg::reg_addr_w-1:0] rn_idx,
    input  logic [arm_pkg::reg_addr_w-1:0] rm_idx,
    output logic [arm_pkg::word_w-1:0]     rn_data,
    output logic [arm_pkg::word_w-1:0]     rm_data
);
    import arm_pkg::*;

    logic [word_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle writes reach decode through forward_unit
    assign rn_data = regs[rn_idx];
    assign rm_data = regs[rm_idx];

endmodule

`default_nettype wire

/* source/decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  arm_pkg::instr_t                 id_instr,
    input  logic [arm_pkg::word_w-1:0]     id_next_pc,
    input  logic [3:0]                      flags,
    output logic [arm_pkg::reg_addr_w-1:0] rn_idx,
    output logic [arm_pkg::reg_addr_w-1:0] rm_idx,
    output logic [arm_pkg::reg_addr_w-1:0] rd,
    output logic [3:0]                      alu_op,
    output logic                            imm_mode,
    output logic                            s_en,
    output logic                            wr_en,
    output logic [11:0]                     operand_field,
    output logic                            branch_taken,
    output logic [arm_pkg::word_w-1:0]     branch_target
);
    import arm_pkg::*;

    logic              n_flag;
    logic              z_flag;
    logic              c_flag;
    logic              v_flag;
    logic              kept_op;
    logic              is_dp;
    logic              is_branch;
    logic              cond_pass;
    logic [word_w-1:0] offset_bytes;

    assign {n_flag, z_flag, c_flag, v_flag} = flags;

    // TST, TEQ, CMP and CMN sit at 10xx
    assign kept_op = (id_instr.dp.opcode[3:2] != 2'b10);

    // Register form only with an immediate shift amount
    assign is_dp = kept_op && (id_instr != '0) &&
                   ((id_instr.dp.cls == class_dp_imm) ||
                    (id_instr.dp.cls == class_dp_reg && !id_instr.dp.operand[4]));

    assign is_branch = (id_instr.br.cls == class_branch) && !id_instr.br.link;

    assign rn_idx        = id_instr.dp.rn;
    assign rm_idx        = id_instr.dp.operand[3:0];
    assign rd            = id_instr.dp.rd;
    assign alu_op        = id_instr.dp.opcode;
    assign imm_mode      = (id_instr.dp.cls == class_dp_imm);
    assign operand_field = id_instr.dp.operand;
    assign wr_en         = is_dp;
    assign s_en          = is_dp && id_instr.dp.s;

    always_comb begin
        case (id_instr.br.cond)
            4'b0000: cond_pass = z_flag;                        // EQ
            4'b0001: cond_pass = !z_flag;                       // NE
            4'b0010: cond_pass = c_flag;                        // CS
            4'b0011: cond_pass = !c_flag;                       // CC
            4'b0100: cond_pass = n_flag;                        // MI
            4'b0101: cond_pass = !n_flag;                       // PL
            4'b0110: cond_pass = v_flag;                        // VS
            4'b0111: cond_pass = !v_flag;                       // VC
            4'b1000: cond_pass = c_flag && !z_flag;             // HI
            4'b1001: cond_pass = !c_flag || z_flag;             // LS
            4'b1010: cond_pass = (n_flag == v_flag);            // GE
            4'b1011: cond_pass = (n_flag != v_flag);            // LT
            4'b1100: cond_pass = !z_flag && (n_flag == v_flag); // GT
            4'b1101: cond_pass = z_flag || (n_flag != v_flag);  // LE
            cond_al: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    assign offset_bytes  = {{(word_w-26){id_instr.br.offset[23]}}, id_instr.br.offset, 2'b00};
    assign branch_target = id_next_pc + offset_bytes;
    assign branch_taken  = is_branch && cond_pass;

    // A redirect would squash its own result otherwise
    always_comb begin
        assert final (!(branch_taken && wr_en))
            else $error("branch taken together with a register write");
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        branch_taken,
    input  logic [arm_pkg::word_w-1:0] branch_target,
    input  logic [arm_pkg::word_w-1:0] instr,
    output logic [arm_pkg::word_w-1:0] pc,
    output arm_pkg::instr_t             id_instr,
    output logic [arm_pkg::word_w-1:0] id_next_pc
);
    import arm_pkg::*;

    logic [word_w-1:0] seq_pc;

    assign seq_pc = pc + word_w'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            id_instr <= '0;
        end else begin
            pc       <= branch_taken ? branch_target : seq_pc;
            id_instr <= branch_taken ? '0 : instr; // Wrong-path word becomes NOP
        end
    end

    always_ff @(posedge clk) begin
        id_next_pc <= seq_pc;
    end

    // Redirects come from decode, so this also covers the target adder
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

`default_nettype wire

/* source/arm_pkg.sv */
`default_nettype none

package arm_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 4;

    // Opcode field values, which the ALU takes as its operation
    localparam logic [3:0] op_and = 4'b0000;
    localparam logic [3:0] op_eor = 4'b0001;
    localparam logic [3:0] op_sub = 4'b0010;
    localparam logic [3:0] op_rsb = 4'b0011;
    localparam logic [3:0] op_add = 4'b0100;
    localparam logic [3:0] op_adc = 4'b0101;
    localparam logic [3:0] op_sbc = 4'b0110;
    localparam logic [3:0] op_rsc = 4'b0111;
    localparam logic [3:0] op_orr = 4'b1100;
    localparam logic [3:0] op_mov = 4'b1101;
    localparam logic [3:0] op_bic = 4'b1110;
    localparam logic [3:0] op_mvn = 4'b1111;

    localparam logic [2:0] class_dp_reg = 3'b000; // Bits 27 to 25
    localparam logic [2:0] class_dp_imm = 3'b001;
    localparam logic [2:0] class_branch = 3'b101;

    localparam logic [1:0] shift_lsl = 2'b00;
    localparam logic [1:0] shift_lsr = 2'b01;
    localparam logic [1:0] shift_asr = 2'b10;
    localparam logic [1:0] shift_ror = 2'b11;

    localparam logic [3:0] cond_al = 4'b1110;

    // Operand source select
    localparam logic [1:0] fwd_file = 2'b00;
    localparam logic [1:0] fwd_ex   = 2'b01;
    localparam logic [1:0] fwd_wb   = 2'b10;

    typedef union packed {
        struct packed {
            logic [3:0]            cond;
            logic [2:0]            cls;
            logic [3:0]            opcode;
            logic                  s;
            logic [reg_addr_w-1:0] rn;
            logic [reg_addr_w-1:0] rd;
            logic [11:0]           operand;
        } dp;
        struct packed {
            logic [3:0]  cond;
            logic [2:0]  cls;
            logic        link;
            logic [23:0] offset; // Signed word offset
        } br;
    } instr_t;

endpackage

`default_nettype wire
